/* filelist.f */
+incdir+include
verilog/dbg_pkg.sv
verilog/dbg_chain_select.sv
verilog/dbg_bus_module.sv
verilog/dbg_cpu_module.sv
verilog/dbg_top.sv
tb/dbg_tb.sv

/* tb/dbg_tb.sv */
//////////////////////////////////////////////////////////////////////
// Debug unit testbench
// Directed JTAG scans against the bus and CPU control modules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "dbg_cfg.svh"

module dbg_tb;

  import dbg_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;

  logic                      tck_i;
  logic                      tlr_i;
  logic                      tdi_i;
  logic                      shift_dr_i;
  logic                      capture_dr_i;
  logic                      update_dr_i;
  logic                      debug_select_i;
  logic                      bus_ack_i;
  logic [31:0]               bus_rdata_i;
  logic [`DBG_NUM_CORES-1:0] cpu_bp_i;
  logic                      tdo_o;
  logic                      bus_req_o;
  dbg_bus_req_t              bus_req_data_o;
  logic [`DBG_NUM_CORES-1:0] cpu_stall_o;

  // Monitor and responder bookkeeping
  logic [31:0]  lcg_state = 32'h5bff;
  int           req_count = 0;
  int           ack_count = 0;
  dbg_bus_req_t last_req;
  logic [31:0]  last_ack_data;
  logic         ack_hold = 1'b0;

  dbg_top dut (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .tdi_i          (tdi_i),
    .shift_dr_i     (shift_dr_i),
    .capture_dr_i   (capture_dr_i),
    .update_dr_i    (update_dr_i),
    .debug_select_i (debug_select_i),
    .bus_ack_i      (bus_ack_i),
    .bus_rdata_i    (bus_rdata_i),
    .cpu_bp_i       (cpu_bp_i),
    .tdo_o          (tdo_o),
    .bus_req_o      (bus_req_o),
    .bus_req_data_o (bus_req_data_o),
    .cpu_stall_o    (cpu_stall_o)
  );

  initial begin
    tck_i = 1'b0;
    forever #4 tck_i = ~tck_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [63:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Select flag on top, id right below it, ones as filler
  function automatic logic [63:0] select_word(input logic [1:0] id);
    return {1'b1, id, {61{1'b1}}};
  endfunction

  // Bus view, MSB field first under a clear flag
  function automatic logic [63:0] bus_cmd_word(input logic [3:0] op, input logic [15:0] addr,
                                               input logic [31:0] data);
    return {1'b0, op, addr, data, 11'b0};
  endfunction

  function automatic logic [63:0] stall_cmd_word(input logic [3:0] mask);
    return {1'b0, `DBG_OP_CPU_STALL, mask, 55'b0};
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic wait_for_req(input int target);
    int cycles;
    cycles = 0;
    while (req_count < target) begin
      if (cycles == TIMEOUT_CYCLES) begin
        stop_run("Timeout: the DUT never raised the bus request strobe");
      end
      @(negedge tck_i);
      cycles++;
    end
  endtask

  task automatic wait_for_ack(input int target);
    int cycles;
    cycles = 0;
    while (ack_count < target) begin
      if (cycles == TIMEOUT_CYCLES) begin
        stop_run("Timeout: the bus responder never acknowledged the read");
      end
      @(negedge tck_i);
      cycles++;
    end
  endtask

  // Capture, 64 shifts LSB first, then update
  task automatic jtag_scan(input logic [63:0] din, output logic [63:0] dout);
    @(posedge tck_i);
    capture_dr_i <= 1'b1;
    @(posedge tck_i);
    capture_dr_i <= 1'b0;
    shift_dr_i   <= 1'b1;
    tdi_i        <= din[0];
    for (int i = 0; i < `DBG_DATAREG_LEN; i++) begin
      // tdo is settled mid-cycle
      @(negedge tck_i);
      dout[i] = tdo_o;
      @(posedge tck_i);
      if (i < `DBG_DATAREG_LEN - 1) begin
        tdi_i <= din[i+1];
      end else begin
        shift_dr_i  <= 1'b0;
        update_dr_i <= 1'b1;
      end
    end
    @(posedge tck_i);
    update_dr_i <= 1'b0;
    tdi_i       <= 1'b0;
  endtask

  task automatic jtag_write_dr(input logic [63:0] din);
    logic [63:0] unused_out;
    jtag_scan(din, unused_out);
  endtask

  // Zeros shifted in decode as a no-op command
  task automatic jtag_read_dr(output logic [63:0] dout);
    jtag_scan(64'b0, dout);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus monitor and responder
  //////////////////////////////////////////////////////////////////////

  always @(negedge tck_i) begin
    if (bus_req_o === 1'b1) begin
      last_req  = bus_req_data_o;
      req_count = req_count + 1;
    end
  end

  // Reads get an ack with random data after 1 to 8 cycles
  initial begin : bus_responder
    int          delay;
    int          cycles;
    logic [31:0] data;
    bus_ack_i   = 1'b0;
    bus_rdata_i = '0;
    forever begin
      @(negedge tck_i);
      if (bus_req_o === 1'b1 && bus_req_data_o.write === 1'b0) begin
        cycles = 0;
        while (ack_hold) begin
          if (cycles == TIMEOUT_CYCLES) begin
            stop_run("Timeout: the read acknowledge was held back too long");
          end
          @(negedge tck_i);
          cycles++;
        end
        delay = 1 + (lcg_next() % 8);
        data  = lcg_next();
        repeat (delay) @(posedge tck_i);
        bus_rdata_i <= data;
        bus_ack_i   <= 1'b1;
        @(posedge tck_i);
        bus_ack_i     <= 1'b0;
        last_ack_data = data;
        ack_count     = ack_count + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    logic [63:0] rd;
    @(negedge tck_i);
    check_value("bus_req_o after reset", bus_req_o, 0);
    check_value("cpu_stall_o after reset", cpu_stall_o, 0);
    jtag_read_dr(rd);
    check_value("bus chain before any access", rd, 0);
  endtask

  task automatic test_bus_write();
    logic [31:0] rnd;
    logic [15:0] addr;
    logic [31:0] data;
    int          base;
    rnd  = lcg_next();
    addr = rnd[15:0];
    data = lcg_next();
    jtag_write_dr(select_word(`DBG_BUS_MODULE));
    base = req_count;
    jtag_write_dr(bus_cmd_word(`DBG_OP_BUS_WRITE, addr, data));
    wait_for_req(base + 1);
    // Any second strobe would show up here
    repeat (8) @(negedge tck_i);
    check_value("bus write strobe count", req_count, base + 1);
    check_value("bus write flag", last_req.write, 1);
    check_value("bus write address", last_req.addr, addr);
    check_value("bus write data", last_req.wdata, data);
  endtask

  task automatic test_bus_read();
    logic [31:0] rnd;
    logic [63:0] rd;
    int          base_ack;
    rnd      = lcg_next();
    base_ack = ack_count;
    jtag_write_dr(bus_cmd_word(`DBG_OP_BUS_READ, rnd[15:0], 32'h0));
    wait_for_req(req_count + 1);
    check_value("bus read flag", last_req.write, 0);
    check_value("bus read address", last_req.addr, rnd[15:0]);
    wait_for_ack(base_ack + 1);
    jtag_read_dr(rd);
    check_value("bus read data", rd, {32'b0, last_ack_data});
  endtask

  task automatic test_inhibited_select();
    logic [31:0] rnd;
    logic [63:0] rd;
    int          base_ack;
    rnd      = lcg_next();
    base_ack = ack_count;
    ack_hold = 1'b1;
    jtag_write_dr(bus_cmd_word(`DBG_OP_BUS_READ, rnd[15:0], 32'h0));
    wait_for_req(req_count + 1);
    // Read still outstanding, this select must not take
    jtag_write_dr(select_word(`DBG_CPU_MODULE));
    ack_hold = 1'b0;
    wait_for_ack(base_ack + 1);
    jtag_read_dr(rd);
    check_value("bus data after inhibited select", rd, {32'b0, last_ack_data});
  endtask

  task automatic test_cpu_stall();
    logic [63:0] rd;
    jtag_write_dr(select_word(`DBG_CPU_MODULE));
    @(posedge tck_i);
    cpu_bp_i <= 4'b0110;
    jtag_write_dr(stall_cmd_word(4'b1010));
    @(negedge tck_i);
    check_value("cpu_stall_o", cpu_stall_o, 4'b1010);
    jtag_read_dr(rd);
    check_value("cpu status word", rd, 64'h6A);
  endtask

  // Bus shift register keeps the filler ones while id 3 is read
  task automatic test_empty_slot();
    logic [63:0] rd;
    jtag_write_dr(select_word(`DBG_BUS_MODULE));
    jtag_write_dr(select_word(`DBG_RESERVED_MODULE));
    jtag_read_dr(rd);
    check_value("empty slot chain", rd, 0);
  endtask

  initial begin
    tlr_i          = 1'b1;
    tdi_i          = 1'b0;
    shift_dr_i     = 1'b0;
    capture_dr_i   = 1'b0;
    update_dr_i    = 1'b0;
    debug_select_i = 1'b1;
    cpu_bp_i       = '0;
    repeat (8) @(posedge tck_i);
    tlr_i <= 1'b0;
    test_reset_state();
    test_bus_write();
    test_bus_read();
    test_inhibited_select();
    test_cpu_stall();
    test_empty_slot();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/dbg_top.sv */
//////////////////////////////////////////////////////////////////////
// Debug unit top
// Chain select with the bus and CPU control modules behind it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "dbg_cfg.svh"

module dbg_top (
  input  wire                       tck_i,
  input  wire                       tlr_i,
  input  wire                       tdi_i,
  input  wire                       shift_dr_i,
  input  wire                       capture_dr_i,
  input  wire                       update_dr_i,
  input  wire                       debug_select_i,
  input  wire                       bus_ack_i,
  input  wire  [31:0]               bus_rdata_i,
  input  wire  [`DBG_NUM_CORES-1:0] cpu_bp_i,
  output logic                      tdo_o,
  output logic                      bus_req_o,
  output dbg_pkg::dbg_bus_req_t     bus_req_data_o,
  output logic [`DBG_NUM_CORES-1:0] cpu_stall_o
);

  import dbg_pkg::*;

  // Shared command bus and per-module returns
  dbg_cmd_u                    cmd;
  logic                        cmd_stb;
  logic [`DBG_MAX_MODULES-1:0] sel;
  logic                        bus_inhibit;
  logic                        bus_tdo;
  logic                        cpu_tdo;

  dbg_chain_select u_chain_select (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .tdi_i          (tdi_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .debug_select_i (debug_select_i),
    .inhibit_i      (bus_inhibit),
    .bus_tdo_i      (bus_tdo),
    .cpu_tdo_i      (cpu_tdo),
    .cmd_o          (cmd),
    .cmd_stb_o      (cmd_stb),
    .sel_o          (sel),
    .tdo_o          (tdo_o)
  );

  dbg_bus_module u_bus_module (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .tdi_i          (tdi_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .cmd_i          (cmd),
    .cmd_stb_i      (cmd_stb),
    .sel_i          (sel[`DBG_BUS_MODULE]),
    .bus_ack_i      (bus_ack_i),
    .bus_rdata_i    (bus_rdata_i),
    .bus_req_o      (bus_req_o),
    .bus_req_data_o (bus_req_data_o),
    .inhibit_o      (bus_inhibit),
    .tdo_o          (bus_tdo)
  );

  dbg_cpu_module u_cpu_module (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .cmd_i          (cmd),
    .cmd_stb_i      (cmd_stb),
    .sel_i          (sel[`DBG_CPU_MODULE]),
    .cpu_bp_i       (cpu_bp_i),
    .cpu_stall_o    (cpu_stall_o),
    .tdo_o          (cpu_tdo)
  );

endmodule

`default_nettype wire

/* verilog/dbg_cpu_module.sv */
//////////////////////////////////////////////////////////////////////
// Debug CPU control module
// Per-core stall bits and a stall/breakpoint status readout
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "dbg_cfg.svh"

module dbg_cpu_module (
  input  wire                       tck_i,
  input  wire                       tlr_i,
  input  wire                       capture_dr_i,
  input  wire                       shift_dr_i,
  input  dbg_pkg::dbg_cmd_u         cmd_i,
  input  wire                       cmd_stb_i,
  input  wire                       sel_i,
  input  wire  [`DBG_NUM_CORES-1:0] cpu_bp_i,
  output logic [`DBG_NUM_CORES-1:0] cpu_stall_o,
  output logic                      tdo_o
);

  import dbg_pkg::*;

  dbg_cpu_cmd_t                cpu_cmd;
  logic                        stall_load;
  logic [`DBG_DATAREG_LEN-1:0] out_q;

  //////////////////////////////////////////////////////////////////////
  // Stall register
  //////////////////////////////////////////////////////////////////////

  assign cpu_cmd    = cmd_i.cpu;
  assign stall_load = cmd_stb_i & sel_i & (cpu_cmd.opcode == `DBG_OP_CPU_STALL);

  // New mask on the edge that sees the strobe
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      cpu_stall_o <= '0;
    end else if (stall_load) begin
      cpu_stall_o <= cpu_cmd.stall_mask;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Status capture and shift
  //////////////////////////////////////////////////////////////////////

  // Status word: breakpoints above stall bits
  always_ff @(posedge tck_i) begin
    if (capture_dr_i && sel_i) begin
      out_q <= {{(`DBG_DATAREG_LEN-2*`DBG_NUM_CORES){1'b0}}, cpu_bp_i, cpu_stall_o};
    end else if (shift_dr_i && sel_i) begin
      // Zeros fill from the top
      out_q <= {1'b0, out_q[`DBG_DATAREG_LEN-1:1]};
    end
  end

  assign tdo_o = out_q[0];

endmodule

`default_nettype wire

/* verilog/dbg_bus_module.sv */
//////////////////////////////////////////////////////////////////////
// Debug bus module
// Single-strobe bus writes and reads, read data shifted out on tdo
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "dbg_cfg.svh"

module dbg_bus_module (
  input  wire                   tck_i,
  input  wire                   tlr_i,
  input  wire                   tdi_i,
  input  wire                   capture_dr_i,
  input  wire                   shift_dr_i,
  input  dbg_pkg::dbg_cmd_u     cmd_i,
  input  wire                   cmd_stb_i,
  input  wire                   sel_i,
  input  wire                   bus_ack_i,
  input  wire  [31:0]           bus_rdata_i,
  output logic                  bus_req_o,
  output dbg_pkg::dbg_bus_req_t bus_req_data_o,
  output logic                  inhibit_o,
  output logic                  tdo_o
);

  import dbg_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////////////////////////

  dbg_bus_cmd_t                bus_cmd;
  logic                        cmd_write;
  logic                        cmd_read;
  logic                        cmd_accept;
  logic                        req_pend_q;
  logic                        busy_q;
  logic [31:0]                 rdata_q;
  logic [`DBG_DATAREG_LEN-1:0] out_q;

  assign bus_cmd   = cmd_i.bus;
  assign cmd_write = (bus_cmd.opcode == `DBG_OP_BUS_WRITE);
  assign cmd_read  = (bus_cmd.opcode == `DBG_OP_BUS_READ);

  // Commands during an outstanding read are dropped
  assign cmd_accept = cmd_stb_i & sel_i & ~busy_q & (cmd_write | cmd_read);

  //////////////////////////////////////////////////////////////////////
  // Request and handshake
  //////////////////////////////////////////////////////////////////////

  // Request fields, loaded with the accepted command
  always_ff @(posedge tck_i) begin
    if (cmd_accept) begin
      bus_req_data_o.write <= cmd_write;
      bus_req_data_o.addr  <= bus_cmd.addr;
      bus_req_data_o.wdata <= bus_cmd.wdata;
    end
  end

  // Strobe follows one cycle after the request is registered
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      req_pend_q <= 1'b0;
      bus_req_o  <= 1'b0;
    end else begin
      req_pend_q <= cmd_accept;
      bus_req_o  <= req_pend_q;
    end
  end

  // Busy from read accept until ack
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      busy_q <= 1'b0;
    end else if (cmd_accept && cmd_read) begin
      busy_q <= 1'b1;
    end else if (bus_ack_i) begin
      busy_q <= 1'b0;
    end
  end

  // Keeps the top level on this module mid-read
  assign inhibit_o = busy_q;

  // Read data, zero until the first ack
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      rdata_q <= '0;
    end else if (bus_ack_i && busy_q) begin
      rdata_q <= bus_rdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Capture and shift
  //////////////////////////////////////////////////////////////////////

  // Read data zero extended, then shifted out LSB first
  always_ff @(posedge tck_i) begin
    if (capture_dr_i && sel_i) begin
      out_q <= {{(`DBG_DATAREG_LEN-32){1'b0}}, rdata_q};
    end else if (shift_dr_i && sel_i) begin
      out_q <= {tdi_i, out_q[`DBG_DATAREG_LEN-1:1]};
    end
  end

  assign tdo_o = out_q[0];

endmodule

`default_nettype wire

/* verilog/dbg_chain_select.sv */
//////////////////////////////////////////////////////////////////////
// Debug chain select
// Main shift register, module id latch, one-hot select and tdo mux
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "dbg_cfg.svh"

module dbg_chain_select (
  input  wire                         tck_i,
  input  wire                         tlr_i,
  input  wire                         tdi_i,
  input  wire                         shift_dr_i,
  input  wire                         update_dr_i,
  input  wire                         debug_select_i,
  input  wire                         inhibit_i,
  input  wire                         bus_tdo_i,
  input  wire                         cpu_tdo_i,
  output dbg_pkg::dbg_cmd_u           cmd_o,
  output logic                        cmd_stb_o,
  output logic [`DBG_MAX_MODULES-1:0] sel_o,
  output logic                        tdo_o
);

  //////////////////////////////////////////////////////////////////////
  // Registers and decode
  //////////////////////////////////////////////////////////////////////

  logic [`DBG_DATAREG_LEN-1:0]   chain_q;
  logic [`DBG_MODULE_ID_LEN-1:0] module_id_q;
  logic                          select_word;
  logic [`DBG_MODULE_ID_LEN-1:0] module_id_in;

  // Top bit flags a select word
  assign select_word  = chain_q[`DBG_DATAREG_LEN-1];
  // Id sits right below the flag
  assign module_id_in = chain_q[`DBG_DATAREG_LEN-2 -: `DBG_MODULE_ID_LEN];

  // Everything below the flag goes out as the command
  assign cmd_o = chain_q[`DBG_DATAREG_LEN-2:0];

  // Command strobe, not gated per module
  assign cmd_stb_o = update_dr_i & debug_select_i & ~select_word;

  //////////////////////////////////////////////////////////////////////
  // Main chain
  //////////////////////////////////////////////////////////////////////

  // LSB first, tdi enters at the top
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      chain_q <= '0;
    end else if (shift_dr_i && debug_select_i) begin
      chain_q <= {tdi_i, chain_q[`DBG_DATAREG_LEN-1:1]};
    end
  end

  // Module id, held while a module asks for inhibit
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      module_id_q <= '0;
    end else if (update_dr_i && debug_select_i && select_word && !inhibit_i) begin
      module_id_q <= module_id_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Select decode and tdo mux
  //////////////////////////////////////////////////////////////////////

  // One-hot select
  always_comb begin
    sel_o              = '0;
    sel_o[module_id_q] = 1'b1;
  end

  // Empty slots read back zeros
  always_comb begin
    case (module_id_q)
      `DBG_BUS_MODULE:      tdo_o = bus_tdo_i;
      `DBG_CPU_MODULE:      tdo_o = cpu_tdo_i;
      `DBG_JSP_MODULE:      tdo_o = 1'b0;
      `DBG_RESERVED_MODULE: tdo_o = 1'b0;
      default:              tdo_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/dbg_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Debug unit types
// Two views of the command bits and the bus request bundle
//////////////////////////////////////////////////////////////////////

`default_nettype none

package dbg_pkg;

  `include "dbg_cfg.svh"

  // Bus view, opcode in the top bits of the chain
  typedef struct packed {
    logic [3:0]  opcode;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic [10:0] unused;
  } dbg_bus_cmd_t;

  // CPU view of the same bits
  typedef struct packed {
    logic [3:0]                                   opcode;
    logic [`DBG_NUM_CORES-1:0]                    stall_mask;
    logic [`DBG_DATAREG_LEN-6-`DBG_NUM_CORES:0]   unused;
  } dbg_cpu_cmd_t;

  // Chain bits 62..0, decoded by whichever module is selected
  typedef union packed {
    dbg_bus_cmd_t bus;
    dbg_cpu_cmd_t cpu;
  } dbg_cmd_u;

  // Request carried with the bus strobe
  typedef struct packed {
    logic        write;
    logic [15:0] addr;
    logic [31:0] wdata;
  } dbg_bus_req_t;

endpackage

`default_nettype wire

/* include/dbg_cfg.svh */
//////////////////////////////////////////////////////////////////////
// Debug unit configuration
// Chain geometry, module ids, command opcodes and core count
//////////////////////////////////////////////////////////////////////

`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// Main chain geometry
`define DBG_DATAREG_LEN      64
`define DBG_MODULE_ID_LEN    2
`define DBG_MAX_MODULES      4

// Module slots behind the select word
`define DBG_BUS_MODULE       2'd0
`define DBG_CPU_MODULE       2'd1
`define DBG_JSP_MODULE       2'd2
`define DBG_RESERVED_MODULE  2'd3

// Bus module opcodes
`define DBG_OP_BUS_WRITE     4'h1
`define DBG_OP_BUS_READ      4'h2

// CPU control opcodes
`define DBG_OP_CPU_STALL     4'h1
`define DBG_OP_CPU_STATUS    4'h2

// Cores with stall and breakpoint lines
`define DBG_NUM_CORES        4

`endif
